// ==== rtl/srt_macros.svh ====
`ifndef SRT_MACROS_SVH
`define SRT_MACROS_SVH

// record FIFO holds 2**4 entries
`define SRT_FIFO_DEPTH_LOG2 4

// serial bit period in clocks
`define SRT_DEFAULT_CLKS_PER_BIT 16'd4
// anything below this cannot hold a mid-bit sample
`define SRT_MIN_CLKS_PER_BIT 16'd2

// channel tag placed in the low field of every record
`define SRT_DEFAULT_CHANNEL 16'h0002

// marker codes, each sent twice in the payload field
`define SRT_LINE_CODE 16'h000D
`define SRT_FRAME_CODE 16'h000E

// 48-bit record split into bytes on the line
`define SRT_BYTES_PER_RECORD 6

`endif

// ==== rtl/srt_pkg.sv ====
package srt_pkg;

    // timing-converter word or marker payload
    typedef logic [31:0] payload_t;

    // channel tag in the low record field
    typedef logic [15:0] channel_t;

    // payload above tag
    typedef logic [47:0] record_t;

    // clocks per serial bit
    typedef logic [15:0] clk_div_t;

    // event selected by the packer in one cycle
    typedef enum logic [1:0] {
        ev_none,
        ev_data,
        ev_line,
        ev_frame
    } event_kind_e;

    // per-byte serial framing
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_bits,
        tx_stop
    } tx_state_e;

endpackage

// ==== rtl/link_config.sv ====
`timescale 1ns/1ns
`include "srt_macros.svh"

module link_config (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg_wr,
    input  srt_pkg::clk_div_t cfg_clks_per_bit,
    input  srt_pkg::channel_t cfg_channel,
    output srt_pkg::clk_div_t clks_per_bit,
    output srt_pkg::channel_t channel
);

    logic period_ok;

    // short periods are refused, tag is still taken
    assign period_ok = cfg_clks_per_bit >= `SRT_MIN_CLKS_PER_BIT;

    always_ff @(posedge clk) begin
        if (rst) begin
            clks_per_bit <= `SRT_DEFAULT_CLKS_PER_BIT;
        end else if (cfg_wr && period_ok) begin
            clks_per_bit <= cfg_clks_per_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            channel <= `SRT_DEFAULT_CHANNEL;
        end else if (cfg_wr) begin
            channel <= cfg_channel;
        end
    end

    // transmitter relies on at least two clocks per bit
    // for the whole run, whatever was written
    a_period_min: assert property (
        @(posedge clk) disable iff (rst)
        clks_per_bit >= `SRT_MIN_CLKS_PER_BIT
    ) else $error("stored bit period below minimum");

endmodule

// ==== rtl/event_packer.sv ====
`timescale 1ns/1ns
`include "srt_macros.svh"

module event_packer (
    input  logic              clk,
    input  logic              rst,
    input  logic              data_valid,
    input  logic              line_req,
    input  logic              frame_req,
    input  srt_pkg::payload_t din,
    input  srt_pkg::channel_t channel,
    input  logic              push_ok,
    output logic              wr_en,
    output srt_pkg::record_t  wr_data,
    output logic              data_done,
    output logic              line_done,
    output logic              frame_done
);

    srt_pkg::event_kind_e kind_d;
    srt_pkg::event_kind_e kind_q;
    srt_pkg::payload_t    payload_d;

    // data beats line, line beats frame
    always_comb begin
        kind_d    = srt_pkg::ev_none;
        payload_d = din;
        if (data_valid) begin
            kind_d = srt_pkg::ev_data;
        end else if (line_req) begin
            kind_d    = srt_pkg::ev_line;
            payload_d = {`SRT_LINE_CODE, `SRT_LINE_CODE};
        end else if (frame_req) begin
            kind_d    = srt_pkg::ev_frame;
            payload_d = {`SRT_FRAME_CODE, `SRT_FRAME_CODE};
        end
    end

    // write strobe and kind, one cycle after the event
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en  <= 1'b0;
            kind_q <= srt_pkg::ev_none;
        end else begin
            wr_en  <= kind_d != srt_pkg::ev_none;
            kind_q <= kind_d;
        end
    end

    // record payload, tag always in the low field
    always_ff @(posedge clk) begin
        if (kind_d != srt_pkg::ev_none) begin
            wr_data <= {payload_d, channel};
        end
    end

    // done only when the FIFO took the record
    always_ff @(posedge clk) begin
        if (rst) begin
            data_done  <= 1'b0;
            line_done  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            data_done  <= push_ok && kind_q == srt_pkg::ev_data;
            line_done  <= push_ok && kind_q == srt_pkg::ev_line;
            frame_done <= push_ok && kind_q == srt_pkg::ev_frame;
        end
    end

    // FIFO acceptance must map back to exactly one kind
    a_done_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({data_done, line_done, frame_done})
    ) else $error("more than one done pulse");

endmodule

// ==== rtl/record_fifo.sv ====
`timescale 1ns/1ns
`include "srt_macros.svh"

module record_fifo #(
    parameter int DEPTH_LOG2 = `SRT_FIFO_DEPTH_LOG2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  srt_pkg::record_t wr_data,
    output logic             push_ok,
    input  logic             pop,
    output srt_pkg::record_t rd_data,
    output logic             fifo_empty,
    output logic             overflow
);

    localparam logic [DEPTH_LOG2:0] FULL_COUNT = 1 << DEPTH_LOG2;

    srt_pkg::record_t mem [0:(1 << DEPTH_LOG2) - 1];

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  full;
    logic                  do_pop;

    assign fifo_empty = count == '0;
    assign full       = count == FULL_COUNT;
    assign do_pop     = pop && !fifo_empty;

    // a pop in the same cycle frees the slot of a full FIFO
    assign push_ok = wr_en && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data valid the cycle after pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (wr_en && !push_ok) begin
            overflow <= 1'b1;
        end
    end

    // drain control must never ask an empty queue
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !fifo_empty
    ) else $error("pop while FIFO empty");

endmodule

// ==== rtl/record_uart_tx.sv ====
`timescale 1ns/1ns
`include "srt_macros.svh"

module record_uart_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              fifo_empty,
    output logic              pop,
    input  srt_pkg::record_t  rd_data,
    input  srt_pkg::clk_div_t clks_per_bit,
    output logic              tx,
    output logic              busy
);

    srt_pkg::tx_state_e state;
    srt_pkg::record_t   shreg;
    srt_pkg::clk_div_t  period_q;
    srt_pkg::clk_div_t  cnt;
    logic [2:0]         bit_idx;
    logic [2:0]         byte_idx;
    logic               pop_q;
    logic               bit_end;
    logic [7:0]         cur_byte;

    // drain rule, pop_q covers the launch already in flight
    assign pop = !fifo_empty && state == srt_pkg::tx_idle && !pop_q;

    assign busy     = state != srt_pkg::tx_idle;
    assign bit_end  = cnt == period_q - 16'd1;
    // most significant byte goes first
    assign cur_byte = shreg[47:40];

    always_ff @(posedge clk) begin
        if (rst) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= srt_pkg::tx_idle;
            tx       <= 1'b1;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                srt_pkg::tx_idle: begin
                    tx <= 1'b1;
                    // FIFO data arrives the cycle after pop
                    if (pop_q) begin
                        state    <= srt_pkg::tx_start;
                        tx       <= 1'b0;
                        cnt      <= '0;
                        byte_idx <= '0;
                    end
                end
                srt_pkg::tx_start: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        tx      <= cur_byte[0];
                        state   <= srt_pkg::tx_bits;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                srt_pkg::tx_bits: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= srt_pkg::tx_stop;
                        end else begin
                            // lsb first within the byte
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= cur_byte[bit_idx + 3'd1];
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                srt_pkg::tx_stop: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (byte_idx == 3'(`SRT_BYTES_PER_RECORD - 1)) begin
                            state <= srt_pkg::tx_idle;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                            tx       <= 1'b0;
                            state    <= srt_pkg::tx_start;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    state <= srt_pkg::tx_idle;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    // record and bit period held for the whole record
    always_ff @(posedge clk) begin
        if (state == srt_pkg::tx_idle && pop_q) begin
            shreg    <= rd_data;
            period_q <= clks_per_bit;
        end else if (state == srt_pkg::tx_stop && bit_end) begin
            shreg <= {shreg[39:0], 8'h00};
        end
    end

    // line must rest at mark between records
    a_idle_mark: assert property (
        @(posedge clk) disable iff (rst)
        state == srt_pkg::tx_idle |-> tx
    ) else $error("tx low while idle");

endmodule

// ==== rtl/sensor_record_tx.sv ====
`timescale 1ns/1ns

module sensor_record_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              data_valid,
    input  logic              line_req,
    input  logic              frame_req,
    input  srt_pkg::payload_t din,
    input  logic              cfg_wr,
    input  srt_pkg::clk_div_t cfg_clks_per_bit,
    input  srt_pkg::channel_t cfg_channel,
    output logic              data_done,
    output logic              line_done,
    output logic              frame_done,
    output logic              overflow,
    output logic              tx,
    output logic              busy
);

    srt_pkg::clk_div_t clks_per_bit;
    srt_pkg::channel_t channel;
    srt_pkg::record_t  wr_data;
    srt_pkg::record_t  rd_data;
    logic              wr_en;
    logic              push_ok;
    logic              pop;
    logic              fifo_empty;

    // stored tag and bit period
    link_config u_link_config (
        .clk              (clk),
        .rst              (rst),
        .cfg_wr           (cfg_wr),
        .cfg_clks_per_bit (cfg_clks_per_bit),
        .cfg_channel      (cfg_channel),
        .clks_per_bit     (clks_per_bit),
        .channel          (channel)
    );

    event_packer u_event_packer (
        .clk        (clk),
        .rst        (rst),
        .data_valid (data_valid),
        .line_req   (line_req),
        .frame_req  (frame_req),
        .din        (din),
        .channel    (channel),
        .push_ok    (push_ok),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .data_done  (data_done),
        .line_done  (line_done),
        .frame_done (frame_done)
    );

    record_fifo u_record_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .push_ok    (push_ok),
        .pop        (pop),
        .rd_data    (rd_data),
        .fifo_empty (fifo_empty),
        .overflow   (overflow)
    );

    // drains the FIFO onto the serial line
    record_uart_tx u_record_uart_tx (
        .clk          (clk),
        .rst          (rst),
        .fifo_empty   (fifo_empty),
        .pop          (pop),
        .rd_data      (rd_data),
        .clks_per_bit (clks_per_bit),
        .tx           (tx),
        .busy         (busy)
    );

endmodule

// ==== tb/srt_tests.svh ====
// payload above tag on the link
function automatic srt_pkg::record_t expected_record(input srt_pkg::payload_t p,
                                                    input srt_pkg::channel_t tag);
    return {p, tag};
endfunction

// all callers sit 1 ns after a rising edge
task automatic apply_reset();
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst        = 1'b0;
    cur_period = DEFAULT_PERIOD;
    cur_tag    = DEFAULT_TAG;
    rx_queue.delete();
endtask

// one-cycle strobe
// returns where the done pulse should be visible
task automatic send_event(input logic dv, input logic lr, input logic fr,
                          input srt_pkg::payload_t p);
    data_valid = dv;
    line_req   = lr;
    frame_req  = fr;
    din        = p;
    @(posedge clk);
    #1;
    data_valid = 1'b0;
    line_req   = 1'b0;
    frame_req  = 1'b0;
    @(posedge clk);
    #1;
endtask

// back-to-back data strobes
// done of event i shows one iteration later
task automatic send_burst(input int n);
    int i;
    for (i = 0; i <= n; i++) begin
        if (i < n) begin
            burst_payload[i] = $random(seed);
            din              = burst_payload[i];
            data_valid       = 1'b1;
        end else begin
            data_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        if (i > 0) begin
            burst_taken[i-1] = data_done;
        end
    end
endtask

task automatic write_config(input srt_pkg::clk_div_t period, input srt_pkg::channel_t tag);
    cfg_wr           = 1'b1;
    cfg_clks_per_bit = period;
    cfg_channel      = tag;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
    // short periods are refused
    // the tag always lands
    if (period >= 16'd2) begin
        cur_period = period;
    end
    cur_tag = tag;
endtask

task automatic wait_record(input string label, output srt_pkg::record_t r);
    int n;
    n = 0;
    while (rx_queue.size() == 0 && n < 120 * cur_period + 50) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (rx_queue.size() == 0) begin
        errors++;
        $display("%s: no record arrived on tx within %0d cycles", label, n);
        r = 'x;
    end else begin
        r = rx_queue.pop_front();
    end
endtask

task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 200 * cur_period) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (busy) begin
        errors++;
        $display("transmitter still busy after %0d cycles", n);
    end
endtask

// clocks from capture to the end of the last stop bit
task automatic measure_busy(output int cycles);
    int n;
    n      = 0;
    cycles = 0;
    while (!busy && n < 20) begin
        @(posedge clk);
        #1;
        n++;
    end
    while (busy && cycles < 100 * cur_period) begin
        @(posedge clk);
        #1;
        cycles++;
    end
endtask

task automatic reset_defaults();
    apply_reset();
    check_pulse("tx after reset", tx, 1'b1);
    check_pulse("busy after reset", busy, 1'b0);
    check_pulse("data_done after reset", data_done, 1'b0);
    check_pulse("line_done after reset", line_done, 1'b0);
    check_pulse("frame_done after reset", frame_done, 1'b0);
    check_pulse("overflow after reset", overflow, 1'b0);
    end_test("reset defaults");
endtask

task automatic single_data_event();
    srt_pkg::payload_t p;
    srt_pkg::record_t  r;
    p = $random(seed);
    send_event(1'b1, 1'b0, 1'b0, p);
    check_pulse("data_done", data_done, 1'b1);
    check_pulse("line_done on data", line_done, 1'b0);
    check_pulse("frame_done on data", frame_done, 1'b0);
    wait_record("single data", r);
    check_record("single data record", r, expected_record(p, cur_tag));
    wait_idle();
    end_test("single data");
endtask

task automatic marker_events();
    srt_pkg::payload_t p;
    srt_pkg::record_t  r;
    send_event(1'b0, 1'b1, 1'b0, '0);
    check_pulse("line_done", line_done, 1'b1);
    check_pulse("data_done on line", data_done, 1'b0);
    wait_record("line marker", r);
    check_record("line marker record", r, expected_record(LINE_PAYLOAD, cur_tag));
    wait_idle();
    send_event(1'b0, 1'b0, 1'b1, '0);
    check_pulse("frame_done", frame_done, 1'b1);
    check_pulse("line_done on frame", line_done, 1'b0);
    wait_record("frame marker", r);
    check_record("frame marker record", r, expected_record(FRAME_PAYLOAD, cur_tag));
    wait_idle();
    // all three at once and data wins
    p = $random(seed);
    send_event(1'b1, 1'b1, 1'b1, p);
    check_pulse("data_done on collision", data_done, 1'b1);
    check_pulse("line_done on collision", line_done, 1'b0);
    check_pulse("frame_done on collision", frame_done, 1'b0);
    wait_record("collision", r);
    check_record("collision record", r, expected_record(p, cur_tag));
    wait_idle();
    // long enough for a stray marker record to reach the receiver
    repeat (70 * cur_period) @(posedge clk);
    #1;
    check_pulse("busy after collision", busy, 1'b0);
    check_pulse("extra record after collision", rx_queue.size() != 0, 1'b0);
    end_test("markers");
endtask

task automatic data_burst();
    srt_pkg::record_t r;
    int               i;
    send_burst(8);
    for (i = 0; i < 8; i++) begin
        check_pulse($sformatf("burst data_done %0d", i), burst_taken[i], 1'b1);
    end
    for (i = 0; i < 8; i++) begin
        wait_record("burst", r);
        check_record($sformatf("burst record %0d", i), r,
                     expected_record(burst_payload[i], cur_tag));
    end
    wait_idle();
    end_test("data burst");
endtask

task automatic config_update();
    srt_pkg::payload_t p;
    srt_pkg::record_t  r;
    int                cyc;
    int                k;
    write_config(16'd6, 16'h00A5);
    // second write has a bad period
    // only its tag counts
    for (k = 0; k < 2; k++) begin
        if (k == 1) begin
            write_config(16'd1, 16'h005A);
        end
        p = $random(seed);
        send_event(1'b1, 1'b0, 1'b0, p);
        check_pulse("data_done after config", data_done, 1'b1);
        measure_busy(cyc);
        check_period("bit period after config",
                     srt_pkg::clk_div_t'((cyc % 60 == 0) ? cyc / 60 : 0), 16'd6);
        wait_record("config", r);
        check_record("record after config", r, expected_record(p, cur_tag));
    end
    end_test("config update");
endtask

task automatic fifo_overflow();
    srt_pkg::record_t r;
    int               i;
    int               taken;
    apply_reset();
    send_burst(20);
    // 16 queued plus at most one already launched
    taken = 0;
    for (i = 0; i < 20; i++) begin
        if (i < FIFO_DEPTH) begin
            check_pulse($sformatf("overflow burst done %0d", i), burst_taken[i], 1'b1);
        end else if (i > FIFO_DEPTH) begin
            check_pulse($sformatf("done for dropped event %0d", i), burst_taken[i], 1'b0);
        end
        if (burst_taken[i] === 1'b1) begin
            taken++;
        end
    end
    check_pulse("overflow set", overflow, 1'b1);
    for (i = 0; i < taken; i++) begin
        wait_record("overflow burst", r);
        check_record($sformatf("overflow record %0d", i), r,
                     expected_record(burst_payload[i], cur_tag));
    end
    wait_idle();
    // a record kept without a done pulse would show up here
    repeat (70 * cur_period) @(posedge clk);
    #1;
    check_pulse("overflow held", overflow, 1'b1);
    check_pulse("extra record after overflow", rx_queue.size() != 0, 1'b0);
    apply_reset();
    check_pulse("overflow cleared by reset", overflow, 1'b0);
    end_test("fifo overflow");
endtask

// ==== tb/tb_sensor_record_tx.sv ====
`timescale 1ns/1ns

module tb_sensor_record_tx;

    localparam int CLK_NS = 4;
    // records sent over the run at period 4 and at period 6
    localparam int FAST_RECORDS = 29;
    localparam int SLOW_RECORDS = 2;
    // 60 bit periods per record, doubled as margin
    localparam int WATCHDOG_NS = 2 * CLK_NS * 60 * (FAST_RECORDS * 4 + SLOW_RECORDS * 6);
    localparam int FIFO_DEPTH = 16;

    localparam srt_pkg::clk_div_t DEFAULT_PERIOD = 16'd4;
    localparam srt_pkg::channel_t DEFAULT_TAG    = 16'h0002;
    localparam srt_pkg::payload_t LINE_PAYLOAD   = 32'h000D_000D;
    localparam srt_pkg::payload_t FRAME_PAYLOAD  = 32'h000E_000E;

    logic              clk;
    logic              rst;
    logic              data_valid;
    logic              line_req;
    logic              frame_req;
    srt_pkg::payload_t din;
    logic              cfg_wr;
    srt_pkg::clk_div_t cfg_clks_per_bit;
    srt_pkg::channel_t cfg_channel;
    logic              data_done;
    logic              line_done;
    logic              frame_done;
    logic              overflow;
    logic              tx;
    logic              busy;

    // receiver model state, period and tag as the link should be configured
    srt_pkg::clk_div_t cur_period;
    srt_pkg::channel_t cur_tag;
    srt_pkg::record_t  rx_queue[$];
    srt_pkg::payload_t burst_payload [0:31];
    logic              burst_taken [0:31];
    integer            seed;
    int                errors;
    int                checks;
    int                tests;
    int                errors_base;

    sensor_record_tx dut (
        .clk              (clk),
        .rst              (rst),
        .data_valid       (data_valid),
        .line_req         (line_req),
        .frame_req        (frame_req),
        .din              (din),
        .cfg_wr           (cfg_wr),
        .cfg_clks_per_bit (cfg_clks_per_bit),
        .cfg_channel      (cfg_channel),
        .data_done        (data_done),
        .line_done        (line_done),
        .frame_done       (frame_done),
        .overflow         (overflow),
        .tx               (tx),
        .busy             (busy)
    );

    `include "srt_tests.svh"

    task automatic check_record(input string label, input srt_pkg::record_t got,
                                input srt_pkg::record_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s got %h expected %h", $time, label, got, exp);
        end
    endtask

    task automatic check_pulse(input string label, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s got %b expected %b", $time, label, got, exp);
        end
    endtask

    task automatic check_period(input string label, input srt_pkg::clk_div_t got,
                                input srt_pkg::clk_div_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s got %0d expected %0d", $time, label, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-18s finished at %0t ns with %0d errors", name, $time, errors - errors_base);
        errors_base = errors;
    endtask

    // one 8N1 byte, sampled mid-bit, lsb first
    task automatic receive_byte(output logic [7:0] b, output logic framing_ok);
        srt_pkg::clk_div_t period;
        int                k;
        @(negedge tx);
        period = cur_period;
        repeat (period / 2) @(posedge clk);
        #1;
        framing_ok = !tx;
        for (k = 0; k < 8; k++) begin
            repeat (period) @(posedge clk);
            #1;
            b[k] = tx;
        end
        repeat (period) @(posedge clk);
        #1;
        framing_ok = framing_ok && tx;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // six bytes per record, most significant first
    initial begin : serial_receiver
        srt_pkg::record_t rec;
        logic [7:0]       b;
        logic             ok;
        int               k;
        forever begin
            for (k = 0; k < 6; k++) begin
                receive_byte(b, ok);
                if (!ok) begin
                    errors++;
                    $display("** Error @ %0t ns: framing error on tx", $time);
                end
                rec = {rec[39:0], b};
            end
            rx_queue.push_back(rec);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst              = 1'b1;
        data_valid       = 1'b0;
        line_req         = 1'b0;
        frame_req        = 1'b0;
        din              = '0;
        cfg_wr           = 1'b0;
        cfg_clks_per_bit = '0;
        cfg_channel      = '0;
        seed             = 32'h6109;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        errors_base      = 0;
        cur_period       = DEFAULT_PERIOD;
        cur_tag          = DEFAULT_TAG;
        reset_defaults();
        single_data_event();
        marker_events();
        data_burst();
        config_update();
        fifo_overflow();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sensor_record_tx.f ====
+incdir+rtl
+incdir+tb
rtl/srt_pkg.sv
rtl/link_config.sv
rtl/event_packer.sv
rtl/record_fifo.sv
rtl/record_uart_tx.sv
rtl/sensor_record_tx.sv
tb/tb_sensor_record_tx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then scan the log for the failure banner
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sensor_record_tx -f sensor_record_tx.f \
    -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
